/* bench/tb_sc_datapath.sv */
// testbench for the scoreboarded datapath: imem model, in-order reference and directed tests
module tb_sc_datapath
    import datapath_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 5;
    localparam int REQ_LIMIT  = 5;
    localparam int HALT_LIMIT = 5000;
    localparam int QUIET      = 20;

    logic    CLK      = 1'b0;
    logic    nrst     = 1'b0;
    logic    ihit     = 1'b0;
    word_t   imemload = '0;
    logic    imemREN;
    word_t   imemaddr;
    logic    wb_valid;
    regsel_t wb_rd;
    word_t   wb_data;
    logic    halt;

    integer  seed = 11946;
    int      lat_cnt = 0;
    int      errors = 0;
    int      checks = 0;
    int      timeouts = 0;
    int      wb_count = 0;
    logic    timed_out = 1'b0;

    // program image, expected writebacks in program order
    word_t   prog [$];
    regsel_t exp_rd [$];
    word_t   exp_data [$];

    sc_datapath #(.NUM_FU(3), .MUL_CYCLES(4)) dut (
        .CLK, .nrst, .ihit, .imemload,
        .imemREN, .imemaddr, .wb_valid, .wb_rd, .wb_data, .halt
    );

    // 20 ns period
    always #10 CLK = ~CLK;

    // program words, past the end a HALT tagged with the address
    function automatic word_t fetch_word(word_t addr);
        if (addr < prog.size()) begin
            return prog[addr];
        end
        return {OP_HALT, addr[27:0] ^ {24'h0, addr[31:28]}};
    endfunction

    // instruction memory, random latency, one-cycle hit strobe
    always @(posedge CLK) begin
        #2;
        if (!nrst) begin
            ihit    = 1'b0;
            lat_cnt = 0;
        end else if (ihit) begin
            ihit = 1'b0;
        end else if (imemREN) begin
            if (lat_cnt == 0) begin
                ihit     = 1'b1;
                imemload = fetch_word(imemaddr);
                lat_cnt  = $unsigned($random(seed)) % 4;
            end else begin
                lat_cnt = lat_cnt - 1;
            end
        end
    end

    function automatic word_t enc_r(opcode_t op, int rd, int rs1, int rs2);
        instr_u u;
        u              = '0;
        u.r_fmt.opcode = op;
        u.r_fmt.rd     = regsel_t'(rd);
        u.r_fmt.rs1    = regsel_t'(rs1);
        u.r_fmt.rs2    = regsel_t'(rs2);
        return u;
    endfunction

    function automatic word_t enc_i(opcode_t op, int rd, int rs1, int imm);
        instr_u u;
        u              = '0;
        u.i_fmt.opcode = op;
        u.i_fmt.rd     = regsel_t'(rd);
        u.i_fmt.rs1    = regsel_t'(rs1);
        u.i_fmt.imm    = imm[19:0];
        return u;
    endfunction

    // in-order execution of prog up to the first HALT
    task automatic run_reference();
        word_t  r [REG_COUNT];
        instr_u u;
        word_t  a;
        word_t  b;
        word_t  v;
        logic   stop;
        for (int k = 0; k < REG_COUNT; k++) begin
            r[k] = '0;
        end
        stop = 1'b0;
        for (int i = 0; i < prog.size() && !stop; i++) begin
            u = prog[i];
            a = r[u.r_fmt.rs1];
            b = r[u.r_fmt.rs2];
            v = '0;
            case (u.r_fmt.opcode)
                OP_ADD:  v = a + b;
                OP_SUB:  v = a - b;
                OP_AND:  v = a & b;
                OP_OR:   v = a | b;
                OP_XOR:  v = a ^ b;
                OP_ADDI: v = a + 32'($signed(u.i_fmt.imm));
                OP_MUL:  v = a * b;
                default: stop = 1'b1;
            endcase
            // r0 stays zero and produces no writeback
            if (!stop && u.r_fmt.rd != '0) begin
                r[u.r_fmt.rd] = v;
                exp_rd.push_back(u.r_fmt.rd);
                exp_data.push_back(v);
            end
        end
    endtask

    // compare against the oldest pending value for the same register
    task automatic check_wb(input wb_t got);
        int  idx;
        wb_t exp;
        idx    = -1;
        checks = checks + 1;
        for (int i = 0; i < exp_rd.size(); i++) begin
            if (idx < 0 && exp_rd[i] == got.rd) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            errors = errors + 1;
            $display("writeback to r%0d with data %h had no expected value", got.rd, got.data);
        end else begin
            exp = {1'b1, exp_rd[idx], exp_data[idx]};
            if (got !== exp) begin
                errors = errors + 1;
                $display("Fail wb_data r%0d: got %h expected %h", got.rd, got.data, exp.data);
            end
            exp_rd.delete(idx);
            exp_data.delete(idx);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            errors = errors + 1;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts  = timeouts + 1;
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    // one cycle, outputs sampled mid-cycle, wb events checked on the spot
    task automatic tick();
        wb_t ev;
        @(negedge CLK);
        if (nrst === 1'b1 && wb_valid === 1'b1) begin
            ev       = {wb_valid, wb_rd, wb_data};
            wb_count = wb_count + 1;
            check_wb(ev);
        end
    endtask

    // reset pulse, then the first fetch request
    task automatic apply_reset();
        int n;
        @(posedge CLK);
        #2 nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge CLK);
        #2 nrst = 1'b1;
        tick();
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("halt", halt, 1'b0);
        n = 0;
        while (imemREN !== 1'b1 && !timed_out) begin
            if (n >= REQ_LIMIT) begin
                report_timeout("no instruction request after reset");
            end else begin
                tick();
                n = n + 1;
            end
        end
        if (!timed_out) begin
            check_word("imemaddr", imemaddr, '0);
        end
    endtask

    // reset, run prog to halt, then watch the halted machine
    task automatic run_program(input string name);
        int n;
        int expected;
        $display("running %s", name);
        exp_rd.delete();
        exp_data.delete();
        run_reference();
        expected = exp_rd.size();
        wb_count = 0;
        apply_reset();
        n = 0;
        while (halt !== 1'b1 && !timed_out) begin
            if (n >= HALT_LIMIT) begin
                report_timeout("halt was not raised");
            end else begin
                tick();
                n = n + 1;
            end
        end
        if (!timed_out) begin
            // every writeback must be out by the time halt rises
            if (exp_rd.size() != 0) begin
                errors = errors + 1;
                $display("%0d expected writebacks were missing when halt rose", exp_rd.size());
            end
            check_count("wb_count", wb_count, expected);
            for (int i = 0; i < QUIET; i++) begin
                tick();
                check_flag("halt", halt, 1'b1);
                check_flag("wb_valid", wb_valid, 1'b0);
                check_flag("imemREN", imemREN, 1'b0);
            end
        end
    endtask

    // ADDI and logic ops into distinct registers, r0 write dropped
    task automatic test_straight_line();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 1, 0, 5));
        prog.push_back(enc_i(OP_ADDI, 2, 0, -3));
        prog.push_back(enc_i(OP_ADDI, 3, 0, 'h7ff));
        prog.push_back(enc_r(OP_AND, 4, 1, 3));
        prog.push_back(enc_r(OP_OR, 5, 1, 2));
        prog.push_back(enc_r(OP_XOR, 6, 2, 3));
        prog.push_back(enc_r(OP_SUB, 7, 1, 2));
        prog.push_back(enc_i(OP_ADDI, 0, 0, 9));
        prog.push_back(enc_r(OP_ADD, 8, 4, 5));
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        run_program("straight line");
    endtask

    // mul result feeds add, which feeds xor
    task automatic test_mul_chain();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 1, 0, 123));
        prog.push_back(enc_i(OP_ADDI, 2, 0, -77));
        prog.push_back(enc_r(OP_MUL, 3, 1, 2));
        prog.push_back(enc_r(OP_ADD, 4, 3, 1));
        prog.push_back(enc_r(OP_XOR, 5, 4, 3));
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        run_program("mul chain");
    endtask

    // r6 rewritten between slow muls to other registers
    task automatic test_same_reg_order();
        prog.delete();
        prog.push_back(enc_i(OP_ADDI, 1, 0, 3));
        prog.push_back(enc_i(OP_ADDI, 2, 0, 1000));
        prog.push_back(enc_i(OP_ADDI, 6, 0, 1));
        prog.push_back(enc_r(OP_MUL, 7, 2, 2));
        prog.push_back(enc_i(OP_ADDI, 6, 0, 2));
        prog.push_back(enc_r(OP_MUL, 8, 1, 2));
        prog.push_back(enc_r(OP_ADD, 6, 1, 2));
        prog.push_back(enc_r(OP_MUL, 9, 2, 1));
        prog.push_back(enc_r(OP_XOR, 6, 6, 1));
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        run_program("same register order");
    endtask

    // 40 random ops, ADDI weighted in to seed register values
    task automatic test_random_program();
        int      op_sel;
        opcode_t op;
        int      rd;
        int      rs1;
        int      rs2;
        int      imm;
        prog.delete();
        for (int k = 0; k < 40; k++) begin
            op_sel = $unsigned($random(seed)) % 8;
            op     = (op_sel == 7) ? OP_ADDI : opcode_t'(op_sel);
            rd     = $random(seed) & 15;
            rs1    = $random(seed) & 15;
            rs2    = $random(seed) & 15;
            imm    = $random(seed);
            if (op == OP_ADDI) begin
                prog.push_back(enc_i(op, rd, rs1, imm));
            end else begin
                prog.push_back(enc_r(op, rd, rs1, rs2));
            end
        end
        prog.push_back(enc_r(OP_HALT, 0, 0, 0));
        run_program("random program");
    endtask

    initial begin
        test_straight_line();
        if (!timed_out) begin
            test_mul_chain();
        end
        if (!timed_out) begin
            test_same_reg_order();
        end
        if (!timed_out) begin
            test_random_program();
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* hdl/alu_fu.sv */
// integer functional unit: issue latch, logic ops, multi-cycle multiply and result hold
module alu_fu
    import datapath_pkg::*;
#(
    parameter int MUL_CYCLES = 4
)
(
    input  logic   CLK,
    input  logic   nrst,
    input  issue_t issue,
    input  logic   grant,
    output logic   idle,
    output logic   done,
    output wb_t    result
);
    localparam int CNT_W = $clog2(MUL_CYCLES + 1);

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             finish;
    opcode_t          op;
    regsel_t          rd;
    word_t            a;
    word_t            b;
    word_t            alu_out;
    logic             res_valid;
    regsel_t          res_rd;
    word_t            res_data;

    // last execute cycle
    assign finish = busy & (cnt == '0);

    always_comb begin
        case (op)
            OP_ADD, OP_ADDI: alu_out = a + b;
            OP_SUB:          alu_out = a - b;
            OP_AND:          alu_out = a & b;
            OP_OR:           alu_out = a | b;
            OP_XOR:          alu_out = a ^ b;
            // low word of the product
            OP_MUL:          alu_out = a * b;
            default:         alu_out = '0;
        endcase
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            res_valid <= 1'b0;
        end else begin
            if (issue.valid) begin
                busy <= 1'b1;
                // mul waits out its latency
                cnt  <= (issue.opcode == OP_MUL) ? CNT_W'(MUL_CYCLES - 1) : '0;
            end else if (finish) begin
                busy      <= 1'b0;
                res_valid <= 1'b1;
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
            // hold until writeback takes it
            if (grant) begin
                res_valid <= 1'b0;
            end
        end
    end

    // operand latch and result register
    always_ff @(posedge CLK) begin
        if (issue.valid) begin
            op <= issue.opcode;
            rd <= issue.rd;
            a  <= issue.a;
            b  <= issue.b;
        end
        if (finish) begin
            res_rd   <= rd;
            res_data <= alu_out;
        end
    end

    assign done        = res_valid;
    assign idle        = ~busy & ~res_valid;
    assign result.valid = res_valid;
    assign result.rd    = res_rd;
    assign result.data  = res_data;

endmodule

/* hdl/datapath_pkg.sv */
// shared sizes, opcodes, instruction formats and pipeline latch types for the datapath
package datapath_pkg;

    // data and instruction width
    parameter int WORD_W = 32;
    // architectural registers, r0 reads zero
    parameter int REG_COUNT = 16;

    typedef logic [$clog2(REG_COUNT)-1:0] regsel_t;
    typedef logic [WORD_W-1:0] word_t;

    // 4-bit opcode field, upper half unused
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_MUL  = 4'h6,
        OP_HALT = 4'h7
    } opcode_t;

    // register-register layout
    typedef struct packed {
        opcode_t     opcode;
        regsel_t     rd;
        regsel_t     rs1;
        regsel_t     rs2;
        logic [15:0] unused;
    } r_fmt_t;

    // register-immediate layout, imm is sign extended
    typedef struct packed {
        opcode_t     opcode;
        regsel_t     rd;
        regsel_t     rs1;
        logic [19:0] imm;
    } i_fmt_t;

    // same word seen through either format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // fetch/dispatch latch, 65 bits
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } fd_t;

    // issue/execute payload, 73 bits
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        regsel_t rd;
        word_t   a;
        word_t   b;
    } issue_t;

    // execute/writeback payload, 37 bits
    typedef struct packed {
        logic    valid;
        regsel_t rd;
        word_t   data;
    } wb_t;

endpackage

/* hdl/dispatch.sv */
// dispatch stage: decode, scoreboard, hazard freeze, unit pick, issue and halt detect
module dispatch
    import datapath_pkg::*;
#(
    parameter int NUM_FU = 3
)
(
    input  logic                 CLK,
    input  logic                 nrst,
    input  fd_t                  fd,
    input  word_t                rdat1,
    input  word_t                rdat2,
    input  logic    [NUM_FU-1:0] fu_idle,
    input  logic                 clr_valid,
    input  regsel_t              clr_rd,
    output logic                 freeze,
    output regsel_t              rsel1,
    output regsel_t              rsel2,
    output issue_t  [NUM_FU-1:0] issue,
    output logic                 halt
);
    instr_u               ins;
    opcode_t              op;
    logic [REG_COUNT-1:0] busy;
    logic                 halt_seen;
    logic                 is_halt;
    logic                 uses_rs2;
    logic                 writes_rd;
    logic                 raw;
    logic                 waw;
    logic                 any_idle;
    logic [NUM_FU-1:0]    pick;
    logic                 consume;
    logic                 go;
    word_t                imm_ext;
    word_t                opb;

    assign ins = fd.instr;
    // opcode sits in the same place in both formats
    assign op  = ins.r_fmt.opcode;

    assign is_halt  = (op == OP_HALT);
    // rs2 only for register-register ops
    assign uses_rs2 = (op != OP_ADDI) && !is_halt;
    // writes to r0 are dropped at dispatch
    assign writes_rd = !is_halt && (ins.r_fmt.rd != '0);

    assign rsel1 = ins.r_fmt.rs1;
    assign rsel2 = ins.r_fmt.rs2;

    assign imm_ext = {{(WORD_W-20){ins.i_fmt.imm[19]}}, ins.i_fmt.imm};
    assign opb     = (op == OP_ADDI) ? imm_ext : rdat2;

    // read after write on a pending source
    assign raw = !is_halt && (busy[rsel1] || (uses_rs2 && busy[rsel2]));
    // write after write keeps same-register retire order
    assign waw = writes_rd && busy[ins.r_fmt.rd];

    // lowest idle unit
    assign any_idle = |fu_idle;
    assign pick     = fu_idle & (~fu_idle + 1'b1);

    assign freeze  = halt_seen | (fd.valid & (raw | waw | (writes_rd & ~any_idle)));
    assign consume = fd.valid & ~freeze;
    assign go      = consume & writes_rd;

    // same payload to every unit, valid only at the picked one
    always_comb begin
        for (int i = 0; i < NUM_FU; i++) begin
            issue[i].valid  = go & pick[i];
            issue[i].opcode = op;
            issue[i].rd     = ins.r_fmt.rd;
            issue[i].a      = rdat1;
            issue[i].b      = opb;
        end
    end

    // scoreboard busy bits and halt flag
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy      <= '0;
            halt_seen <= 1'b0;
        end else begin
            if (clr_valid) begin
                busy[clr_rd] <= 1'b0;
            end
            if (go) begin
                busy[ins.r_fmt.rd] <= 1'b1;
            end
            if (consume && is_halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

    // machine drained, stays high since nothing issues after halt
    assign halt = halt_seen & ~(|busy) & (&fu_idle);

endmodule

/* hdl/fetch.sv */
// fetch stage: program counter, instruction memory request and fetch/dispatch latch
module fetch
    import datapath_pkg::*;
(
    input  logic  CLK,
    input  logic  nrst,
    input  logic  ihit,
    input  word_t imemload,
    input  logic  freeze,
    input  logic  halt,
    output logic  imemREN,
    output word_t imemaddr,
    output fd_t   fd
);
    word_t  pc;
    logic   pending;
    logic   load;
    logic   consume;
    logic   fd_valid;
    word_t  fd_pc;
    instr_u fd_instr;

    // returning fetch fills the latch
    assign load    = pending & ihit;
    // dispatch takes the latch this cycle
    assign consume = fd_valid & ~freeze;

    // one request in flight, address held until ihit
    assign imemREN  = pending;
    assign imemaddr = pc;

    assign fd.valid = fd_valid;
    assign fd.pc    = fd_pc;
    assign fd.instr = fd_instr;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc       <= '0;
            pending  <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            // word addressed, one step per instruction
            if (load) begin
                pc <= pc + 1'b1;
            end
            // no new request after halt
            if (halt) begin
                pending <= 1'b0;
            end else if (pending) begin
                pending <= ~ihit;
            end else begin
                // request once the latch is empty
                pending <= ~fd_valid | consume;
            end
            if (load) begin
                fd_valid <= 1'b1;
            end else if (consume) begin
                fd_valid <= 1'b0;
            end
        end
    end

    // latch payload
    always_ff @(posedge CLK) begin
        if (load) begin
            fd_pc    <= pc;
            fd_instr <= imemload;
        end
    end

endmodule

/* hdl/regfile.sv */
// register file with two combinational read ports and one write port, r0 tied to zero
module regfile
    import datapath_pkg::*;
(
    input  logic    CLK,
    input  logic    nrst,
    input  regsel_t rsel1,
    input  regsel_t rsel2,
    input  regsel_t wsel,
    input  logic    wen,
    input  word_t   wdat,
    output word_t   rdat1,
    output word_t   rdat2
);
    word_t regs [REG_COUNT];

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            // r0 never written
            regs[wsel] <= wdat;
        end
    end

    // combinational reads
    assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
    assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

/* hdl/sc_datapath.sv */
// scoreboarded datapath top: fetch, dispatch, register file, alu units and writeback
module sc_datapath
    import datapath_pkg::*;
#(
    parameter int NUM_FU     = 3,
    parameter int MUL_CYCLES = 4
)
(
    input  logic    CLK,
    input  logic    nrst,
    input  logic    ihit,
    input  word_t   imemload,
    output logic    imemREN,
    output word_t   imemaddr,
    output logic    wb_valid,
    output regsel_t wb_rd,
    output word_t   wb_data,
    output logic    halt
);
    // fetch/dispatch
    fd_t                  fd;
    logic                 freeze;
    // register file read side
    regsel_t              rsel1;
    regsel_t              rsel2;
    word_t                rdat1;
    word_t                rdat2;
    // dispatch to units
    issue_t  [NUM_FU-1:0] issue;
    logic    [NUM_FU-1:0] fu_idle;
    // units to writeback
    logic    [NUM_FU-1:0] done;
    wb_t     [NUM_FU-1:0] results;
    logic    [NUM_FU-1:0] grant;
    // writeback to register file and scoreboard
    regsel_t              wsel;
    logic                 wen;
    word_t                wdat;
    logic                 clr_valid;
    regsel_t              clr_rd;
    wb_t                  wb;

    fetch u_fetch (
        .CLK, .nrst, .ihit, .imemload, .freeze, .halt,
        .imemREN, .imemaddr, .fd
    );

    dispatch #(.NUM_FU(NUM_FU)) u_dispatch (
        .CLK, .nrst, .fd, .rdat1, .rdat2, .fu_idle, .clr_valid, .clr_rd,
        .freeze, .rsel1, .rsel2, .issue, .halt
    );

    regfile u_regfile (
        .CLK, .nrst, .rsel1, .rsel2, .wsel, .wen, .wdat, .rdat1, .rdat2
    );

    // identical units, each with its own issue latch
    for (genvar i = 0; i < NUM_FU; i++) begin : g_fu
        alu_fu #(.MUL_CYCLES(MUL_CYCLES)) u_fu (
            .CLK,
            .nrst,
            .issue  (issue[i]),
            .grant  (grant[i]),
            .idle   (fu_idle[i]),
            .done   (done[i]),
            .result (results[i])
        );
    end

    writeback #(.NUM_FU(NUM_FU)) u_writeback (
        .CLK, .nrst, .done, .results,
        .grant, .wsel, .wen, .wdat, .clr_valid, .clr_rd, .wb
    );

    // external writeback port
    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

/* hdl/writeback.sv */
// writeback stage: fixed-priority grant, register write, busy clear and output latch
module writeback
    import datapath_pkg::*;
#(
    parameter int NUM_FU = 3
)
(
    input  logic                 CLK,
    input  logic                 nrst,
    input  logic    [NUM_FU-1:0] done,
    input  wb_t     [NUM_FU-1:0] results,
    output logic    [NUM_FU-1:0] grant,
    output regsel_t              wsel,
    output logic                 wen,
    output word_t                wdat,
    output logic                 clr_valid,
    output regsel_t              clr_rd,
    output wb_t                  wb
);
    wb_t     sel;
    logic    any_done;
    logic    wb_valid;
    regsel_t wb_rd;
    word_t   wb_data;

    // lowest-index finished unit wins
    assign grant    = done & (~done + 1'b1);
    assign any_done = |done;

    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_FU; i++) begin
            if (grant[i]) begin
                sel = results[i];
            end
        end
    end

    // register write and scoreboard clear at the grant edge
    assign wen       = any_done;
    assign wsel      = sel.rd;
    assign wdat      = sel.data;
    assign clr_valid = any_done;
    assign clr_rd    = sel.rd;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= any_done;
        end
    end

    // execute/writeback latch payload
    always_ff @(posedge CLK) begin
        if (any_done) begin
            wb_rd   <= sel.rd;
            wb_data <= sel.data;
        end
    end

    assign wb.valid = wb_valid;
    assign wb.rd    = wb_rd;
    assign wb.data  = wb_data;

endmodule

/* sc_datapath.f */
hdl/datapath_pkg.sv
hdl/fetch.sv
hdl/dispatch.sv
hdl/regfile.sv
hdl/alu_fu.sv
hdl/writeback.sv
hdl/sc_datapath.sv
bench/tb_sc_datapath.sv
